// ==== filelist.f ====
+incdir+tests
logic/mdmc_pkg.sv
logic/ntt_op_ctrl.sv
logic/bfly_index_gen.sv
logic/bitrev_map.sv
logic/mem_addr_issue.sv
logic/writeback_delay.sv
logic/ntt_addr_seq.sv
tests/ntt_addr_seq_tb.sv

// ==== tests/ntt_addr_checks.svh ====
`ifndef NTT_ADDR_CHECKS_SVH
`define NTT_ADDR_CHECKS_SVH

// ------------------------------------------------------------
// reference model of the butterfly order
// ------------------------------------------------------------

function automatic int bit_rev(input int v, input int nbits);
  int r;
  r = 0;
  for (int i = 0; i < nbits; i++) begin
    r = (r << 1) | ((v >> i) & 1);
  end
  return r;
endfunction

function automatic addr_t make_addr(input logic [7:0] base, input int idx);
  return addr_t'(base) * 32'h0100_0000 + addr_t'(idx * 4);   // base x 2^24 + idx x 4
endfunction

task automatic build_expected(input op_mode_e op, input int lg, input logic [7:0] base_a,
                              input logic [7:0] base_b, input logic [7:0] base_t);
  int n;
  int half;
  int lo;
  int hi;
  int tw;
  logic [7:0] rd_base;
  logic [7:0] wr_base;
  n = 1 << lg;
  for (int s = 0; s < lg; s++) begin
    half    = 1 << s;
    rd_base = s[0] ? base_b : base_a;      // ping-pong by stage parity
    wr_base = s[0] ? base_a : base_b;
    for (int g = 0; g < n / (2 * half); g++) begin
      for (int j = 0; j < half; j++) begin
        lo = 2 * half * g + j;
        hi = lo + half;
        tw = j * (n / 2) / half;           // twiddle stays natural
        if (op == OP_NTT) begin
          lo = bit_rev(lo, lg);
          hi = bit_rev(hi, lg);
        end
        exp_rd_lo.push_back(make_addr(rd_base, lo));
        exp_rd_hi.push_back(make_addr(rd_base, hi));
        exp_rd_tw.push_back(make_addr(base_t, tw));
        exp_wr_lo.push_back(make_addr(wr_base, lo));
        exp_wr_hi.push_back(make_addr(wr_base, hi));
      end
    end
  end
endtask

// ------------------------------------------------------------
// compare tasks
// ------------------------------------------------------------

task automatic check_addr(input addr_t got, input addr_t exp, input string what);
  if (got !== exp) begin
    report_failure($sformatf("Error at %0t: %s is 0x%08h, expected 0x%08h",
                             $time, what, got, exp));
  end
endtask

task automatic check_mode(input op_mode_e got, input op_mode_e exp, input string what);
  if (got !== exp) begin
    report_failure($sformatf("Error at %0t: %s is %s, expected %s",
                             $time, what, got.name(), exp.name()));
  end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    report_failure($sformatf("Error at %0t: %s is %b, expected %b", $time, what, got, exp));
  end
endtask

task automatic check_count(input int got, input int exp, input string what);
  if (got != exp) begin
    report_failure($sformatf("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp));
  end
endtask

`endif

// ==== tests/ntt_addr_seq_tb.sv ====
module ntt_addr_seq_tb
  import mdmc_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int POLY_DEG_MAX = 64;
  localparam int BFLY_LAT     = 4;
  localparam int LOG_W        = $clog2($clog2(POLY_DEG_MAX) + 1);
  localparam int NUM_ROWS     = 3;

  typedef struct {
    op_mode_e         op;
    logic [LOG_W-1:0] lg;
    logic [7:0]       base_a;
    logic [7:0]       base_b;
    logic [7:0]       base_t;
    int               exp_count;            // reads and writes per run, log2 N x N/2
  } row_t;

  logic             hclk;
  logic             hresetn;
  logic             trig_ntt;
  logic             trig_intt;
  logic [LOG_W-1:0] poly_log2;
  logic [7:0]       base_addr_a;
  logic [7:0]       base_addr_b;
  logic [7:0]       base_addr_t;
  logic             rd_valid;
  addr_t            rd_addr_lo;
  addr_t            rd_addr_hi;
  addr_t            rd_addr_tw;
  logic             wr_valid;
  addr_t            wr_addr_lo;
  addr_t            wr_addr_hi;
  op_mode_e         mode;
  logic             ntt_done;
  logic             intt_done;

  row_t     rows [NUM_ROWS];
  addr_t    exp_rd_lo [$];
  addr_t    exp_rd_hi [$];
  addr_t    exp_rd_tw [$];
  addr_t    exp_wr_lo [$];
  addr_t    exp_wr_hi [$];
  int       rd_stamp [$];                   // cycle of each read, for write latency
  op_mode_e cur_op = OP_IDLE;
  int       rd_count = 0;
  int       wr_count = 0;
  int       done_cnt = 0;
  int       cycle_cnt = 0;
  int       cycle_limit = 1000;
  int       seed = 93035;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "run stopped");
  endtask

  `include "ntt_addr_checks.svh"

  ntt_addr_seq #(.POLY_DEG_MAX(POLY_DEG_MAX), .BFLY_LAT(BFLY_LAT)) ntt_addr_seq_i (
    .hclk(hclk), .hresetn(hresetn), .trig_ntt(trig_ntt), .trig_intt(trig_intt),
    .poly_log2(poly_log2), .base_addr_a(base_addr_a), .base_addr_b(base_addr_b),
    .base_addr_t(base_addr_t), .rd_valid(rd_valid), .rd_addr_lo(rd_addr_lo),
    .rd_addr_hi(rd_addr_hi), .rd_addr_tw(rd_addr_tw), .wr_valid(wr_valid),
    .wr_addr_lo(wr_addr_lo), .wr_addr_hi(wr_addr_hi), .mode(mode),
    .ntt_done(ntt_done), .intt_done(intt_done)
  );

  initial begin
    hclk = 1'b0;
    forever #10 hclk = ~hclk;
  end

  // ------------------------------------------------------------
  // output monitor, sampled mid-cycle
  // ------------------------------------------------------------

  always @(negedge hclk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      report_failure($sformatf("Timeout: no finish within %0d cycles", cycle_limit));
    end
    if (rd_valid === 1'b1) begin
      if (exp_rd_lo.size() == 0) begin
        report_failure("Unexpected read strobe with no butterfly left to issue");
      end
      check_addr(rd_addr_lo, exp_rd_lo.pop_front(), "rd_addr_lo");
      check_addr(rd_addr_hi, exp_rd_hi.pop_front(), "rd_addr_hi");
      check_addr(rd_addr_tw, exp_rd_tw.pop_front(), "rd_addr_tw");
      rd_stamp.push_back(cycle_cnt);
      rd_count++;
    end
    if (wr_valid === 1'b1) begin
      if (exp_wr_lo.size() == 0 || rd_stamp.size() == 0) begin
        report_failure("Unexpected write strobe with no read before it");
      end
      check_count(cycle_cnt - rd_stamp.pop_front(), BFLY_LAT, "write latency");
      check_addr(wr_addr_lo, exp_wr_lo.pop_front(), "wr_addr_lo");
      check_addr(wr_addr_hi, exp_wr_hi.pop_front(), "wr_addr_hi");
      wr_count++;
    end
    if (ntt_done === 1'b1 || intt_done === 1'b1) begin
      done_cnt++;
      if (exp_wr_lo.size() != 0 || wr_valid === 1'b1) begin
        report_failure("Done pulse arrived before the last write");
      end
      check_bit(ntt_done, cur_op == OP_NTT, "ntt_done");
      check_bit(intt_done, cur_op == OP_INTT, "intt_done");
    end
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------

  function automatic int calc_cycle_limit();
    int total;
    int n;
    total = 100;
    for (int i = 0; i < NUM_ROWS; i++) begin
      n = 1 << rows[i].lg;
      total += rows[i].lg * (n / 2 + 2 + BFLY_LAT + 8);
    end
    return total;
  endfunction

  task automatic check_idle_outputs();
    check_bit(rd_valid, 1'b0, "rd_valid");
    check_bit(wr_valid, 1'b0, "wr_valid");
    check_bit(ntt_done, 1'b0, "ntt_done");
    check_bit(intt_done, 1'b0, "intt_done");
    check_mode(mode, OP_IDLE, "mode");
  endtask

  task automatic run_row(input int i);
    build_expected(rows[i].op, rows[i].lg, rows[i].base_a, rows[i].base_b, rows[i].base_t);
    cur_op   = rows[i].op;
    rd_count = 0;
    wr_count = 0;
    done_cnt = 0;
    @(negedge hclk);
    poly_log2   = rows[i].lg;
    base_addr_a = rows[i].base_a;
    base_addr_b = rows[i].base_b;
    base_addr_t = rows[i].base_t;
    trig_ntt    = (rows[i].op == OP_NTT);
    trig_intt   = (rows[i].op == OP_INTT);
    @(negedge hclk);
    trig_ntt  = 1'b0;
    trig_intt = 1'b0;
    repeat (3) begin
      check_mode(mode, rows[i].op, "mode while busy");
      @(negedge hclk);
    end
    trig_ntt  = 1'b1;                       // retrigger while busy, must be ignored
    trig_intt = 1'b1;
    poly_log2 = LOG_W'(2);
    @(negedge hclk);
    trig_ntt  = 1'b0;
    trig_intt = 1'b0;
    poly_log2 = rows[i].lg;
    while (ntt_done !== 1'b1 && intt_done !== 1'b1) begin
      check_mode(mode, rows[i].op, "mode while busy");
      @(negedge hclk);
    end
    check_mode(mode, rows[i].op, "mode at done");
    @(negedge hclk);
    check_mode(mode, OP_IDLE, "mode after done");
    repeat (10) begin
      @(negedge hclk);
      check_mode(mode, OP_IDLE, "mode after done");
    end
    check_count(rd_count, rows[i].exp_count, "read count");
    check_count(wr_count, rows[i].exp_count, "write count");
    check_count(done_cnt, 1, "done pulses");
    check_count(exp_rd_lo.size(), 0, "reads still expected");
  endtask

  initial begin
    hresetn     = 1'b0;
    trig_ntt    = 1'b0;
    trig_intt   = 1'b0;
    poly_log2   = '0;
    base_addr_a = '0;
    base_addr_b = '0;
    base_addr_t = '0;
    rows[0] = '{OP_NTT,  LOG_W'(3), 8'h00, 8'h00, 8'h00, 12};
    rows[1] = '{OP_NTT,  LOG_W'(6), 8'h00, 8'h00, 8'h00, 192};
    rows[2] = '{OP_INTT, LOG_W'(4), 8'h00, 8'h00, 8'h00, 32};
    for (int i = 0; i < NUM_ROWS; i++) begin
      rows[i].base_a = $random(seed);
      rows[i].base_b = $random(seed);
      rows[i].base_t = $random(seed);
      if (rows[i].base_b == rows[i].base_a) begin
        rows[i].base_b = rows[i].base_a ^ 8'h01;   // keep the two buffers apart
      end
    end
    cycle_limit = calc_cycle_limit();
    repeat (2) begin
      @(negedge hclk);
      check_idle_outputs();
    end
    hresetn = 1'b1;
    @(negedge hclk);
    check_idle_outputs();
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    $display("No errors");
    $finish;
  end

endmodule

// ==== logic/ntt_addr_seq.sv ====
module ntt_addr_seq
  import mdmc_pkg::*;
#(
  parameter int POLY_DEG_MAX = 64,
  parameter int BFLY_LAT     = 4
) (
  input  logic                                        hclk,
  input  logic                                        hresetn,
  input  logic                                        trig_ntt,
  input  logic                                        trig_intt,
  input  logic [$clog2($clog2(POLY_DEG_MAX)+1)-1:0]   poly_log2,
  input  logic [BASE_W-1:0]                           base_addr_a,
  input  logic [BASE_W-1:0]                           base_addr_b,
  input  logic [BASE_W-1:0]                           base_addr_t,
  output logic                                        rd_valid,
  output addr_t                                       rd_addr_lo,
  output addr_t                                       rd_addr_hi,
  output addr_t                                       rd_addr_tw,
  output logic                                        wr_valid,
  output addr_t                                       wr_addr_lo,
  output addr_t                                       wr_addr_hi,
  output op_mode_e                                    mode,
  output logic                                        ntt_done,
  output logic                                        intt_done
);

  localparam int IDX_W = $clog2(POLY_DEG_MAX);
  localparam int LOG_W = $clog2(IDX_W + 1);

  logic             start;
  logic             seq_end;
  op_mode_e         run_mode;
  logic [LOG_W-1:0] run_log2;

  logic             bf_valid;       // generator to bit reversal
  logic [IDX_W-1:0] bf_lo;
  logic [IDX_W-1:0] bf_hi;
  logic [IDX_W-1:0] bf_tw;
  logic             bf_odd;
  op_mode_e         bf_mode;
  logic [LOG_W-1:0] bf_log2;

  logic             br_valid;       // bit reversal to address stage
  logic [IDX_W-1:0] br_lo;
  logic [IDX_W-1:0] br_hi;
  logic [IDX_W-1:0] br_tw;
  logic             br_odd;

  logic             iss_valid;
  addr_t            iss_wr_lo;
  addr_t            iss_wr_hi;

  assign mode = run_mode;

  ntt_op_ctrl #(.POLY_DEG_MAX(POLY_DEG_MAX)) ntt_op_ctrl_i (
    .hclk(hclk), .hresetn(hresetn), .trig_ntt(trig_ntt), .trig_intt(trig_intt),
    .poly_log2(poly_log2), .seq_end(seq_end), .start(start), .run_mode(run_mode),
    .run_log2(run_log2), .ntt_done(ntt_done), .intt_done(intt_done)
  );

  bfly_index_gen #(.POLY_DEG_MAX(POLY_DEG_MAX), .BFLY_LAT(BFLY_LAT)) bfly_index_gen_i (
    .hclk(hclk), .hresetn(hresetn), .start(start), .run_mode(run_mode),
    .run_log2(run_log2), .bf_valid(bf_valid), .idx_lo(bf_lo), .idx_hi(bf_hi),
    .idx_tw(bf_tw), .stage_odd(bf_odd), .bf_mode(bf_mode), .bf_log2(bf_log2),
    .seq_end(seq_end)
  );

  bitrev_map #(.POLY_DEG_MAX(POLY_DEG_MAX)) bitrev_map_i (
    .hclk(hclk), .hresetn(hresetn), .in_valid(bf_valid), .in_lo(bf_lo), .in_hi(bf_hi),
    .in_tw(bf_tw), .in_odd(bf_odd), .in_mode(bf_mode), .in_log2(bf_log2),
    .out_valid(br_valid), .out_lo(br_lo), .out_hi(br_hi), .out_tw(br_tw),
    .out_odd(br_odd)
  );

  mem_addr_issue #(.POLY_DEG_MAX(POLY_DEG_MAX)) mem_addr_issue_i (
    .hclk(hclk), .hresetn(hresetn), .in_valid(br_valid), .in_lo(br_lo), .in_hi(br_hi),
    .in_tw(br_tw), .in_odd(br_odd), .base_addr_a(base_addr_a),
    .base_addr_b(base_addr_b), .base_addr_t(base_addr_t), .rd_valid(rd_valid),
    .rd_addr_lo(rd_addr_lo), .rd_addr_hi(rd_addr_hi), .rd_addr_tw(rd_addr_tw),
    .iss_valid(iss_valid), .iss_wr_lo(iss_wr_lo), .iss_wr_hi(iss_wr_hi)
  );

  writeback_delay #(.BFLY_LAT(BFLY_LAT)) writeback_delay_i (
    .hclk(hclk), .hresetn(hresetn), .in_valid(iss_valid), .in_lo(iss_wr_lo),
    .in_hi(iss_wr_hi), .wr_valid(wr_valid), .wr_addr_lo(wr_addr_lo),
    .wr_addr_hi(wr_addr_hi)
  );

endmodule

// ==== logic/writeback_delay.sv ====
module writeback_delay
  import mdmc_pkg::*;
#(
  parameter int BFLY_LAT = 4
) (
  input  logic  hclk,
  input  logic  hresetn,
  input  logic  in_valid,
  input  addr_t in_lo,
  input  addr_t in_hi,
  output logic  wr_valid,
  output addr_t wr_addr_lo,
  output addr_t wr_addr_hi
);

  logic [BFLY_LAT-1:0] vld_sr;
  addr_t               lo_sr [BFLY_LAT];
  addr_t               hi_sr [BFLY_LAT];

  // ----------------------------------------------------------
  // one slot per cycle of butterfly latency
  // ----------------------------------------------------------

  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      vld_sr <= '0;
    end else begin
      vld_sr[0] <= in_valid;
      for (int i = 1; i < BFLY_LAT; i++) begin
        vld_sr[i] <= vld_sr[i-1];
      end
    end
  end

  always_ff @(posedge hclk) begin
    lo_sr[0] <= in_lo;
    hi_sr[0] <= in_hi;
    for (int i = 1; i < BFLY_LAT; i++) begin
      lo_sr[i] <= lo_sr[i-1];
      hi_sr[i] <= hi_sr[i-1];
    end
  end

  assign wr_valid   = vld_sr[BFLY_LAT-1];
  assign wr_addr_lo = lo_sr[BFLY_LAT-1];   // oldest pair in flight
  assign wr_addr_hi = hi_sr[BFLY_LAT-1];

endmodule

// ==== logic/mem_addr_issue.sv ====
module mem_addr_issue
  import mdmc_pkg::*;
#(
  parameter int POLY_DEG_MAX = 64
) (
  input  logic                            hclk,
  input  logic                            hresetn,
  input  logic                            in_valid,
  input  logic [$clog2(POLY_DEG_MAX)-1:0] in_lo,
  input  logic [$clog2(POLY_DEG_MAX)-1:0] in_hi,
  input  logic [$clog2(POLY_DEG_MAX)-1:0] in_tw,
  input  logic                            in_odd,
  input  logic [BASE_W-1:0]               base_addr_a,
  input  logic [BASE_W-1:0]               base_addr_b,
  input  logic [BASE_W-1:0]               base_addr_t,
  output logic                            rd_valid,
  output addr_t                           rd_addr_lo,
  output addr_t                           rd_addr_hi,
  output addr_t                           rd_addr_tw,
  output logic                            iss_valid,
  output addr_t                           iss_wr_lo,
  output addr_t                           iss_wr_hi
);

  localparam int IDX_W = $clog2(POLY_DEG_MAX);

  logic [BASE_W-1:0] rd_base;
  logic [BASE_W-1:0] wr_base;

  // base in the top byte, word index scaled to bytes
  function automatic addr_t form_addr(input logic [BASE_W-1:0] base,
                                      input logic [IDX_W-1:0]  idx);
    return (addr_t'(base) << (ADDR_W - BASE_W)) | (addr_t'(idx) << WORD_BYTES_LOG2);
  endfunction

  // ----------------------------------------------------------
  // ping-pong by stage parity
  // ----------------------------------------------------------

  assign rd_base = in_odd ? base_addr_b : base_addr_a;
  assign wr_base = in_odd ? base_addr_a : base_addr_b;

  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      rd_valid  <= 1'b0;
      iss_valid <= 1'b0;
    end else begin
      rd_valid  <= in_valid;
      iss_valid <= in_valid;            // write pair enters the delay line
    end
  end

  always_ff @(posedge hclk) begin
    rd_addr_lo <= form_addr(rd_base, in_lo);
    rd_addr_hi <= form_addr(rd_base, in_hi);
    rd_addr_tw <= form_addr(base_addr_t, in_tw);
    iss_wr_lo  <= form_addr(wr_base, in_lo);
    iss_wr_hi  <= form_addr(wr_base, in_hi);
  end

  a_rd_pair_distinct: assert property (@(posedge hclk) disable iff (!hresetn)
    rd_valid |-> (rd_addr_lo != rd_addr_hi))
    else $error("butterfly reads the same address twice");

endmodule

// ==== logic/bitrev_map.sv ====
module bitrev_map
  import mdmc_pkg::*;
#(
  parameter int POLY_DEG_MAX = 64
) (
  input  logic                                        hclk,
  input  logic                                        hresetn,
  input  logic                                        in_valid,
  input  logic [$clog2(POLY_DEG_MAX)-1:0]             in_lo,
  input  logic [$clog2(POLY_DEG_MAX)-1:0]             in_hi,
  input  logic [$clog2(POLY_DEG_MAX)-1:0]             in_tw,
  input  logic                                        in_odd,
  input  op_mode_e                                    in_mode,
  input  logic [$clog2($clog2(POLY_DEG_MAX)+1)-1:0]   in_log2,
  output logic                                        out_valid,
  output logic [$clog2(POLY_DEG_MAX)-1:0]             out_lo,
  output logic [$clog2(POLY_DEG_MAX)-1:0]             out_hi,
  output logic [$clog2(POLY_DEG_MAX)-1:0]             out_tw,
  output logic                                        out_odd
);

  localparam int IDX_W = $clog2(POLY_DEG_MAX);
  localparam int LOG_W = $clog2(IDX_W + 1);

  // reverse the full word, then drop the bits above log2 N
  function automatic logic [IDX_W-1:0] rev_low(input logic [IDX_W-1:0] v,
                                               input logic [LOG_W-1:0] n_bits);
    logic [IDX_W-1:0] r;
    for (int i = 0; i < IDX_W; i++) begin
      r[IDX_W-1-i] = v[i];
    end
    return r >> (IDX_W - n_bits);
  endfunction

  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge hclk) begin
    if (in_mode == OP_NTT) begin
      out_lo <= rev_low(in_lo, in_log2);   // forward transform only
      out_hi <= rev_low(in_hi, in_log2);
    end else begin
      out_lo <= in_lo;
      out_hi <= in_hi;
    end
    out_tw  <= in_tw;                      // twiddle stays natural
    out_odd <= in_odd;
  end

  // reversal is only faithful for indices below N
  a_idx_in_range: assert property (@(posedge hclk) disable iff (!hresetn)
    in_valid |-> (32'(in_lo) < (32'd1 << in_log2)) &&
                 (32'(in_hi) < (32'd1 << in_log2)))
    else $error("index beyond polynomial length before remap");

endmodule

// ==== logic/bfly_index_gen.sv ====
module bfly_index_gen
  import mdmc_pkg::*;
#(
  parameter int POLY_DEG_MAX = 64,
  parameter int BFLY_LAT     = 4
) (
  input  logic                                        hclk,
  input  logic                                        hresetn,
  input  logic                                        start,
  input  op_mode_e                                    run_mode,
  input  logic [$clog2($clog2(POLY_DEG_MAX)+1)-1:0]   run_log2,
  output logic                                        bf_valid,
  output logic [$clog2(POLY_DEG_MAX)-1:0]             idx_lo,
  output logic [$clog2(POLY_DEG_MAX)-1:0]             idx_hi,
  output logic [$clog2(POLY_DEG_MAX)-1:0]             idx_tw,
  output logic                                        stage_odd,
  output op_mode_e                                    bf_mode,
  output logic [$clog2($clog2(POLY_DEG_MAX)+1)-1:0]   bf_log2,
  output logic                                        seq_end
);

  localparam int IDX_W     = $clog2(POLY_DEG_MAX);
  localparam int LOG_W     = $clog2(IDX_W + 1);
  localparam int DRAIN_CYC = 2 + BFLY_LAT;          // last write lands before next read
  localparam int DRN_W     = $clog2(DRAIN_CYC + 1);

  logic             issuing;
  logic             draining;
  logic [DRN_W-1:0] drain_cnt;
  logic [LOG_W-1:0] stage;
  logic [IDX_W-1:0] grp;
  logic [IDX_W-1:0] j_cnt;
  logic [IDX_W-1:0] tw_cnt;
  logic [IDX_W-1:0] stride;

  logic [LOG_W-1:0] c_stage;
  logic [IDX_W-1:0] c_grp;
  logic [IDX_W-1:0] c_j;
  logic [IDX_W-1:0] c_tw;
  logic [IDX_W-1:0] c_stride;
  logic [IDX_W-1:0] half;
  logic [IDX_W-1:0] n_m1;
  logic [IDX_W-1:0] c_lo;
  logic [IDX_W-1:0] c_hi;
  logic             emit;
  logic             last_in_grp;
  logic             last_in_stage;

  // ----------------------------------------------------------
  // current butterfly
  // ----------------------------------------------------------

  // start issues butterfly 0 of stage 0 in the same cycle
  always_comb begin
    if (start) begin
      c_stage  = '0;
      c_grp    = '0;
      c_j      = '0;
      c_tw     = '0;
      c_stride = IDX_W'(1) << (run_log2 - 1'b1);   // N/2
    end else begin
      c_stage  = stage;
      c_grp    = grp;
      c_j      = j_cnt;
      c_tw     = tw_cnt;
      c_stride = stride;
    end
  end

  assign emit          = start | issuing;
  assign half          = IDX_W'(1) << c_stage;
  assign n_m1          = IDX_W'((1 << run_log2) - 1);
  assign c_lo          = IDX_W'(c_grp << (c_stage + 1'b1)) | c_j;
  assign c_hi          = c_lo | half;                  // bit s of lo is always clear
  assign last_in_grp   = (c_j == half - 1'b1);
  assign last_in_stage = (c_hi == n_m1);               // only the final pair reaches N-1

  // ----------------------------------------------------------
  // counters and drain
  // ----------------------------------------------------------

  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      issuing   <= 1'b0;
      draining  <= 1'b0;
      drain_cnt <= '0;
      stage     <= '0;
      grp       <= '0;
      j_cnt     <= '0;
      tw_cnt    <= '0;
      stride    <= '0;
      bf_valid  <= 1'b0;
      seq_end   <= 1'b0;
    end else begin
      seq_end  <= 1'b0;
      bf_valid <= emit;
      if (emit) begin
        if (last_in_stage) begin
          issuing   <= 1'b0;
          draining  <= 1'b1;
          drain_cnt <= '0;
          stage     <= c_stage + 1'b1;
          grp       <= '0;
          j_cnt     <= '0;
          tw_cnt    <= '0;
          stride    <= c_stride >> 1;                  // twiddle step halves
        end else if (last_in_grp) begin
          issuing <= 1'b1;
          stage   <= c_stage;
          grp     <= c_grp + 1'b1;
          j_cnt   <= '0;
          tw_cnt  <= '0;
          stride  <= c_stride;
        end else begin
          issuing <= 1'b1;
          stage   <= c_stage;
          grp     <= c_grp;
          j_cnt   <= c_j + 1'b1;
          tw_cnt  <= c_tw + c_stride;
          stride  <= c_stride;
        end
      end else if (draining) begin
        if (drain_cnt == DRN_W'(DRAIN_CYC - 1)) begin
          draining <= 1'b0;
          if (stage == run_log2) begin
            seq_end <= 1'b1;                           // all stages written
          end else begin
            issuing <= 1'b1;
          end
        end else begin
          drain_cnt <= drain_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge hclk) begin
    if (emit) begin
      idx_lo    <= c_lo;
      idx_hi    <= c_hi;
      idx_tw    <= c_tw;
      stage_odd <= c_stage[0];          // picks the ping-pong buffer
      bf_mode   <= run_mode;
      bf_log2   <= run_log2;
    end
  end

  a_hi_in_range: assert property (@(posedge hclk) disable iff (!hresetn)
    bf_valid |-> (32'(idx_hi) < (32'd1 << bf_log2)))
    else $error("idx_hi beyond polynomial length");

endmodule

// ==== logic/ntt_op_ctrl.sv ====
module ntt_op_ctrl
  import mdmc_pkg::*;
#(
  parameter int POLY_DEG_MAX = 64
) (
  input  logic                                        hclk,
  input  logic                                        hresetn,
  input  logic                                        trig_ntt,
  input  logic                                        trig_intt,
  input  logic [$clog2($clog2(POLY_DEG_MAX)+1)-1:0]   poly_log2,
  input  logic                                        seq_end,
  output logic                                        start,
  output op_mode_e                                    run_mode,
  output logic [$clog2($clog2(POLY_DEG_MAX)+1)-1:0]   run_log2,
  output logic                                        ntt_done,
  output logic                                        intt_done
);

  seq_state_e state;

  // ----------------------------------------------------------
  // run FSM
  // ----------------------------------------------------------

  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      state     <= ST_IDLE;
      run_mode  <= OP_IDLE;
      run_log2  <= '0;
      start     <= 1'b0;
      ntt_done  <= 1'b0;
      intt_done <= 1'b0;
    end else begin
      start     <= 1'b0;                // pulses by default
      ntt_done  <= 1'b0;
      intt_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (trig_ntt || trig_intt) begin
            run_mode <= trig_ntt ? OP_NTT : OP_INTT;   // ntt wins a tie
            run_log2 <= poly_log2;                     // length fixed for the run
            start    <= 1'b1;
            state    <= ST_RUN;
          end
        end
        ST_RUN: begin
          if (seq_end) begin                           // last stage drained
            ntt_done  <= (run_mode == OP_NTT);
            intt_done <= (run_mode == OP_INTT);
            state     <= ST_DONE;
          end
        end
        ST_DONE: begin
          run_mode <= OP_IDLE;          // mode drops after the pulse
          state    <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // the generator only ends a run that is in progress
  a_end_in_run: assert property (@(posedge hclk) disable iff (!hresetn)
    seq_end |-> (state == ST_RUN))
    else $error("seq_end outside a run");

endmodule

// ==== logic/mdmc_pkg.sv ====
package mdmc_pkg;

  // ----------------------------------------------------------
  // operation and controller encodings
  // ----------------------------------------------------------

  typedef enum logic [1:0] {
    OP_IDLE = 2'd0,                     // no transform running
    OP_NTT  = 2'd1,                     // forward, bit-reversed operands
    OP_INTT = 2'd2                      // inverse, natural order
  } op_mode_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_RUN  = 2'd1,                     // stages in flight
    ST_DONE = 2'd2                      // done pulse cycle
  } seq_state_e;

  // ----------------------------------------------------------
  // address map
  // ----------------------------------------------------------

  localparam int ADDR_W          = 32;  // bus address width
  localparam int BASE_W          = 8;   // buffer base, top byte of address
  localparam int WORD_BYTES_LOG2 = 2;   // 32-bit coefficient words

  typedef logic [ADDR_W-1:0] addr_t;

endpackage
